// File: rtl/cpu_pkg.sv
package cpu_pkg;

	localparam int WORD_W = 32;
	localparam int NUM_REGS = 8;
	localparam int REG_IDX_W = $clog2(NUM_REGS);
	localparam int IMM_W = 16;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [WORD_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] instr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;
	typedef logic [IMM_W-1:0] imm_t;

	// byte step between instructions
	localparam addr_t INSTR_BYTES = 4;

	// instruction field positions
	localparam int OPC_HI = 31;
	localparam int OPC_LO = 28;
	localparam int RD_HI = 26;
	localparam int RD_LO = 24;
	localparam int RA_HI = 22;
	localparam int RA_LO = 20;
	localparam int RB_HI = 18;
	localparam int RB_LO = 16;
	localparam int IMM_HI = 15;
	localparam int IMM_LO = 0;

	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_ADDI = 4'h5,
		OP_LDW  = 4'h6,
		OP_STW  = 4'h7,
		// unknown encodings decode to this
		OP_NOP  = 4'h8,
		OP_HALT = 4'hf
	} opcode_e;

	typedef enum logic [1:0] {APB_IDLE, APB_SETUP, APB_ACCESS} apb_state_e;

	typedef enum logic [1:0] {FD_FETCH, FD_WAIT_ISSUE, FD_HALTED} fd_state_e;

endpackage

// File: rtl/mem_port_if.sv
`timescale 1ns/1ps

interface mem_port_if;
	import cpu_pkg::*;

	logic req;
	logic write;
	addr_t addr;
	word_t wdata;
	// valid only while done is high
	word_t rdata;
	logic done;

	modport requester (
		output req,
		output write,
		output addr,
		output wdata,
		input rdata,
		input done
	);

	modport guard (
		input req,
		input write,
		input addr,
		input wdata,
		output rdata,
		output done
	);

endinterface

// File: rtl/dec_op_if.sv
`timescale 1ns/1ps

interface dec_op_if;
	import cpu_pkg::*;

	logic valid;
	opcode_e op;
	reg_idx_t rd;
	reg_idx_t ra;
	reg_idx_t rb;
	imm_t imm;
	// single-cycle pulse, consumes the op
	logic accept;

	modport issuer (
		output valid,
		output op,
		output rd,
		output ra,
		output rb,
		output imm,
		input accept
	);

	modport executor (
		input valid,
		input op,
		input rd,
		input ra,
		input rb,
		input imm,
		output accept
	);

endinterface

// File: rtl/fetch_decode.sv
`timescale 1ns/1ps

module fetch_decode #(
	parameter cpu_pkg::addr_t RESET_PC = '0
) (
	input logic clk,
	input logic rst_n,
	mem_port_if.requester fetch,
	dec_op_if.issuer issue,
	input logic retire,
	output logic halted
);
	import cpu_pkg::*;

	fd_state_e state;
	addr_t pc;
	instr_t ir;
	logic outstanding;
	logic [OPC_HI-OPC_LO:0] raw_op;

	// instruction reads only
	assign fetch.req = (state == FD_FETCH);
	assign fetch.write = 1'b0;
	assign fetch.addr = pc;
	assign fetch.wdata = '0;

	assign raw_op = ir[OPC_HI:OPC_LO];

	always_comb begin
		case (raw_op)
			OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
			OP_ADDI, OP_LDW, OP_STW, OP_HALT: issue.op = opcode_e'(raw_op);
			default: issue.op = OP_NOP;
		endcase
	end

	assign issue.rd = ir[RD_HI:RD_LO];
	assign issue.ra = ir[RA_HI:RA_LO];
	assign issue.rb = ir[RB_HI:RB_LO];
	assign issue.imm = ir[IMM_HI:IMM_LO];

	// one op in execute at a time
	assign issue.valid = (state == FD_WAIT_ISSUE) && !outstanding;
	assign halted = (state == FD_HALTED);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= FD_FETCH;
			pc <= RESET_PC;
			outstanding <= 1'b0;
		end else begin
			if (issue.accept)
				outstanding <= 1'b1;
			else if (retire)
				outstanding <= 1'b0;

			case (state)
				FD_FETCH: begin
					if (fetch.done)
						state <= FD_WAIT_ISSUE;
				end
				FD_WAIT_ISSUE: begin
					if (issue.accept) begin
						if (issue.op == OP_HALT) begin
							state <= FD_HALTED;
						end else begin
							// next fetch overlaps this execute
							state <= FD_FETCH;
							pc <= pc + INSTR_BYTES;
						end
					end
				end
				// stuck here until reset
				FD_HALTED: state <= FD_HALTED;
				default: state <= FD_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == FD_FETCH && fetch.done)
			ir <= fetch.rdata;
	end

endmodule

// File: rtl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input logic clk,
	input logic rst_n,
	dec_op_if.executor issue,
	mem_port_if.requester data,
	output cpu_pkg::reg_idx_t rd_a_idx,
	output cpu_pkg::reg_idx_t rd_b_idx,
	input cpu_pkg::word_t rd_a_data,
	input cpu_pkg::word_t rd_b_data,
	output logic wb_valid,
	output cpu_pkg::reg_idx_t wb_rd,
	output cpu_pkg::word_t wb_data
);
	import cpu_pkg::*;

	logic mem_req;
	logic mem_write;
	addr_t mem_addr;
	word_t mem_wdata;
	reg_idx_t ld_rd;
	logic is_mem;
	logic writes_rd;
	word_t imm_ext;
	word_t addr_sum;
	word_t alu_res;

	// operands come straight from the decoded fields
	assign rd_a_idx = issue.ra;
	assign rd_b_idx = issue.rb;

	assign issue.accept = issue.valid && !mem_req && !wb_valid;

	assign data.req = mem_req;
	assign data.write = mem_write;
	assign data.addr = mem_addr;
	assign data.wdata = mem_wdata;

	assign is_mem = (issue.op == OP_LDW) || (issue.op == OP_STW);
	assign writes_rd = (issue.op == OP_ADD) || (issue.op == OP_SUB) ||
		(issue.op == OP_AND) || (issue.op == OP_OR) ||
		(issue.op == OP_XOR) || (issue.op == OP_ADDI);

	assign imm_ext = {{(WORD_W-IMM_W){issue.imm[IMM_W-1]}}, issue.imm};
	// shared by ADDI and load/store addressing
	assign addr_sum = rd_a_data + imm_ext;

	always_comb begin
		case (issue.op)
			OP_ADD:  alu_res = rd_a_data + rd_b_data;
			OP_SUB:  alu_res = rd_a_data - rd_b_data;
			OP_AND:  alu_res = rd_a_data & rd_b_data;
			OP_OR:   alu_res = rd_a_data | rd_b_data;
			OP_XOR:  alu_res = rd_a_data ^ rd_b_data;
			OP_ADDI: alu_res = addr_sum;
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_req <= 1'b0;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			if (issue.accept) begin
				if (is_mem)
					mem_req <= 1'b1;
				else
					wb_valid <= 1'b1;
			end else if (mem_req && data.done) begin
				mem_req <= 1'b0;
				wb_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue.accept) begin
			// rd zero means retire only
			wb_rd <= writes_rd ? issue.rd : '0;
			wb_data <= alu_res;
			mem_write <= (issue.op == OP_STW);
			mem_addr <= addr_sum;
			mem_wdata <= rd_b_data;
			ld_rd <= (issue.op == OP_LDW) ? issue.rd : '0;
		end else if (mem_req && data.done) begin
			wb_rd <= ld_rd;
			wb_data <= data.rdata;
		end
	end

endmodule

// File: rtl/reg_result.sv
`timescale 1ns/1ps

module reg_result (
	input logic clk,
	input logic rst_n,
	input cpu_pkg::reg_idx_t rd_a_idx,
	input cpu_pkg::reg_idx_t rd_b_idx,
	output cpu_pkg::word_t rd_a_data,
	output cpu_pkg::word_t rd_b_data,
	input logic wb_valid,
	input cpu_pkg::reg_idx_t wb_rd,
	input cpu_pkg::word_t wb_data,
	output logic retire
);
	import cpu_pkg::*;

	word_t regs [NUM_REGS];

	// r0 reads as zero
	assign rd_a_data = (rd_a_idx == '0) ? '0 : regs[rd_a_idx];
	assign rd_b_data = (rd_b_idx == '0) ? '0 : regs[rd_b_idx];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
			retire <= 1'b0;
		end else begin
			// every completion retires, even with no register write
			retire <= wb_valid;
			if (wb_valid && wb_rd != '0)
				regs[wb_rd] <= wb_data;
		end
	end

endmodule

// File: rtl/mem_bus_guard.sv
`timescale 1ns/1ps

module mem_bus_guard (
	input logic clk,
	input logic rst_n,
	mem_port_if.guard fetch,
	mem_port_if.guard data,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output cpu_pkg::addr_t paddr,
	output cpu_pkg::word_t pwdata,
	input cpu_pkg::word_t prdata,
	input logic pready
);
	import cpu_pkg::*;

	apb_state_e state;
	logic sel_data;
	logic done_r;
	word_t rdata_r;
	logic data_elig;
	logic fetch_elig;
	logic start;

	// the finished port still shows its old req during done
	assign data_elig = data.req && !(done_r && sel_data);
	assign fetch_elig = fetch.req && !(done_r && !sel_data);
	assign start = (state == APB_IDLE) && (data_elig || fetch_elig);

	assign psel = (state != APB_IDLE);
	assign penable = (state == APB_ACCESS);

	// route completion back to the latched winner
	assign data.done = done_r && sel_data;
	assign fetch.done = done_r && !sel_data;
	assign data.rdata = rdata_r;
	assign fetch.rdata = rdata_r;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= APB_IDLE;
			sel_data <= 1'b0;
			pwrite <= 1'b0;
			done_r <= 1'b0;
		end else begin
			done_r <= 1'b0;
			case (state)
				APB_IDLE: begin
					if (start) begin
						// data port wins over fetch
						sel_data <= data_elig;
						pwrite <= data_elig ? data.write : fetch.write;
						state <= APB_SETUP;
					end
				end
				APB_SETUP: state <= APB_ACCESS;
				APB_ACCESS: begin
					if (pready) begin
						state <= APB_IDLE;
						done_r <= 1'b1;
					end
				end
				default: state <= APB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			paddr <= data_elig ? data.addr : fetch.addr;
			pwdata <= data_elig ? data.wdata : fetch.wdata;
		end
		if (state == APB_ACCESS && pready)
			rdata_r <= prdata;
	end

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter cpu_pkg::addr_t RESET_PC = 32'h0000_0000
) (
	input logic clk,
	input logic rst_n,
	output logic halted,
	output logic psel,
	output logic penable,
	output logic pwrite,
	output cpu_pkg::addr_t paddr,
	output cpu_pkg::word_t pwdata,
	input cpu_pkg::word_t prdata,
	input logic pready
);
	import cpu_pkg::*;

	reg_idx_t rd_a_idx;
	reg_idx_t rd_b_idx;
	word_t rd_a_data;
	word_t rd_b_data;
	logic wb_valid;
	reg_idx_t wb_rd;
	word_t wb_data;
	logic retire;

	mem_port_if fetch_port ();
	mem_port_if data_port ();
	dec_op_if dec_op ();

	fetch_decode #(
		.RESET_PC(RESET_PC)
	) i_fetch_decode (
		.clk(clk),
		.rst_n(rst_n),
		.fetch(fetch_port.requester),
		.issue(dec_op.issuer),
		.retire(retire),
		.halted(halted)
	);

	execute_unit i_execute_unit (
		.clk(clk),
		.rst_n(rst_n),
		.issue(dec_op.executor),
		.data(data_port.requester),
		.rd_a_idx(rd_a_idx),
		.rd_b_idx(rd_b_idx),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	reg_result i_reg_result (
		.clk(clk),
		.rst_n(rst_n),
		.rd_a_idx(rd_a_idx),
		.rd_b_idx(rd_b_idx),
		.rd_a_data(rd_a_data),
		.rd_b_data(rd_b_data),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.retire(retire)
	);

	mem_bus_guard i_mem_bus_guard (
		.clk(clk),
		.rst_n(rst_n),
		.fetch(fetch_port.guard),
		.data(data_port.guard),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready)
	);

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 8
) (
	output logic clk
);

	// free-running, starts low
	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

// File: testbench/cpu_top_chk.sv
`timescale 1ns/1ps

module cpu_top_chk (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input cpu_pkg::addr_t paddr,
	input cpu_pkg::word_t pwdata,
	input logic pready,
	input logic halted
);

	a_enable_needs_sel: assert property (@(posedge clk) disable iff (!rst_n)
		penable |-> psel)
		else $error("penable high while psel is low");

	// setup phase lasts exactly one cycle
	a_setup_to_access: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && !penable) |=> (psel && penable))
		else $error("setup phase not followed by access phase");

	a_hold_on_wait: assert property (@(posedge clk) disable iff (!rst_n)
		(psel && penable && !pready) |=>
		($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
		else $error("address, direction or write data changed during a wait state");

	// only reset clears halted
	a_halted_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
		else $error("halted dropped without reset");

endmodule

bind cpu_top cpu_top_chk i_cpu_top_chk (
	.clk(clk),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.paddr(paddr),
	.pwdata(pwdata),
	.pready(pready),
	.halted(halted)
);

// File: testbench/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;
	import cpu_pkg::*;

	localparam addr_t RESET_PC = 32'h0000_0040;
	localparam addr_t DATA_BASE = 32'h0000_0200;
	localparam int MEM_WORDS = 256;
	localparam int RAND_LEN = 40;
	localparam int HALT_TIMEOUT = 5000;
	localparam int QUIET_CYCLES = 50;

	logic clk;
	logic rst_n;
	logic halted;
	logic psel;
	logic penable;
	logic pwrite;
	logic pready;
	addr_t paddr;
	word_t pwdata;
	word_t prdata;

	word_t mem [MEM_WORDS];
	word_t ref_mem [MEM_WORDS];
	addr_t exp_fetch [$];
	addr_t exp_ld_addr [$];
	addr_t exp_st_addr [$];
	word_t exp_st_data [$];
	int seed = 70;
	int wait_left;
	int checks = 0;
	int errors = 0;
	bit first_xfer = 1'b0;

	tb_clock_gen #(.PERIOD_NS(8)) i_clock_gen (.clk(clk));

	cpu_top #(
		.RESET_PC(RESET_PC)
	) i_cpu_top (
		.clk(clk),
		.rst_n(rst_n),
		.halted(halted),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready)
	);

	function automatic instr_t encode(logic [3:0] op, reg_idx_t rd, reg_idx_t ra,
		reg_idx_t rb, imm_t imm);
		instr_t w;
		w = '0;
		w[OPC_HI:OPC_LO] = op;
		w[RD_HI:RD_LO] = rd;
		w[RA_HI:RA_LO] = ra;
		w[RB_HI:RB_LO] = rb;
		w[IMM_HI:IMM_LO] = imm;
		return w;
	endfunction

	function automatic word_t fill_word(addr_t a);
		return (a * 32'h9e37_79b1) ^ 32'hc3a5_0f1e;
	endfunction

	// ISA model that walks ref_mem and builds the expected bus traffic
	function automatic void interpret();
		word_t regs [NUM_REGS];
		addr_t pc;
		instr_t w;
		logic [3:0] op;
		reg_idx_t rd;
		word_t a;
		word_t b;
		word_t ea;
		bit done;
		int steps;
		foreach (regs[i])
			regs[i] = '0;
		pc = RESET_PC;
		done = 1'b0;
		steps = 0;
		while (!done && steps < MEM_WORDS) begin
			exp_fetch.push_back(pc);
			w = ref_mem[pc[9:2]];
			op = w[OPC_HI:OPC_LO];
			rd = w[RD_HI:RD_LO];
			a = regs[w[RA_HI:RA_LO]];
			b = regs[w[RB_HI:RB_LO]];
			ea = a + {{(WORD_W-IMM_W){w[IMM_HI]}}, w[IMM_HI:IMM_LO]};
			case (op)
				OP_ADD: regs[rd] = a + b;
				OP_SUB: regs[rd] = a - b;
				OP_AND: regs[rd] = a & b;
				OP_OR: regs[rd] = a | b;
				OP_XOR: regs[rd] = a ^ b;
				OP_ADDI: regs[rd] = ea;
				OP_LDW: begin
					exp_ld_addr.push_back(ea);
					regs[rd] = ref_mem[ea[9:2]];
				end
				OP_STW: begin
					exp_st_addr.push_back(ea);
					exp_st_data.push_back(b);
					ref_mem[ea[9:2]] = b;
				end
				OP_HALT: done = 1'b1;
				default: ;
			endcase
			// r0 stays zero whatever was written
			regs[0] = '0;
			pc = pc + INSTR_BYTES;
			steps++;
		end
	endfunction

	task automatic fill_memory();
		for (int i = 0; i < MEM_WORDS; i++)
			mem[i] = fill_word(addr_t'(i * 4));
	endtask

	task automatic put_instr(input int idx, input instr_t w);
		addr_t a;
		a = RESET_PC + addr_t'(idx * 4);
		mem[a[9:2]] = w;
	endtask

	task automatic build_directed();
		fill_memory();
		put_instr(0, encode(OP_ADDI, 3'd1, 3'd0, 3'd0, 16'h1234));
		put_instr(1, encode(OP_ADDI, 3'd2, 3'd0, 3'd0, 16'hfffd));
		put_instr(2, encode(OP_ADD, 3'd3, 3'd1, 3'd2, 16'h0000));
		put_instr(3, encode(OP_STW, 3'd0, 3'd0, 3'd3, 16'h0200));
		put_instr(4, encode(OP_SUB, 3'd4, 3'd1, 3'd2, 16'h0000));
		put_instr(5, encode(OP_STW, 3'd0, 3'd0, 3'd4, 16'h0204));
		put_instr(6, encode(OP_AND, 3'd5, 3'd1, 3'd2, 16'h0000));
		put_instr(7, encode(OP_STW, 3'd0, 3'd0, 3'd5, 16'h0208));
		put_instr(8, encode(OP_OR, 3'd6, 3'd1, 3'd2, 16'h0000));
		put_instr(9, encode(OP_STW, 3'd0, 3'd0, 3'd6, 16'h020c));
		put_instr(10, encode(OP_XOR, 3'd3, 3'd1, 3'd2, 16'h0000));
		put_instr(11, encode(OP_STW, 3'd0, 3'd0, 3'd3, 16'h0210));
		put_instr(12, encode(OP_ADDI, 3'd4, 3'd1, 3'd0, 16'hffc0));
		put_instr(13, encode(OP_STW, 3'd0, 3'd0, 3'd4, 16'h0214));
		// write to r0, then store it
		put_instr(14, encode(OP_ADDI, 3'd0, 3'd1, 3'd0, 16'h0007));
		put_instr(15, encode(OP_STW, 3'd0, 3'd0, 3'd0, 16'h0218));
		put_instr(16, encode(OP_LDW, 3'd5, 3'd0, 3'd0, 16'h0300));
		put_instr(17, encode(OP_ADD, 3'd6, 3'd5, 3'd1, 16'h0000));
		put_instr(18, encode(OP_STW, 3'd0, 3'd0, 3'd6, 16'h021c));
		// unknown opcode must leave r1 alone
		put_instr(19, encode(4'h9, 3'd1, 3'd2, 3'd2, 16'h0000));
		put_instr(20, encode(OP_STW, 3'd0, 3'd0, 3'd1, 16'h0220));
		put_instr(21, encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
	endtask

	task automatic build_random();
		logic [3:0] op;
		reg_idx_t rd;
		reg_idx_t ra;
		reg_idx_t rb;
		imm_t imm;
		fill_memory();
		// r7 keeps the data base for all loads and stores
		put_instr(0, encode(OP_ADDI, 3'd7, 3'd0, 3'd0, imm_t'(DATA_BASE)));
		for (int i = 1; i < RAND_LEN - 1; i++) begin
			case ($random(seed) & 7)
				0: op = OP_ADD;
				1: op = OP_SUB;
				2: op = OP_AND;
				3: op = OP_OR;
				4: op = OP_XOR;
				5: op = OP_ADDI;
				6: op = OP_LDW;
				default: op = OP_STW;
			endcase
			if (($random(seed) & 15) == 0)
				op = 4'h9;
			rd = reg_idx_t'($random(seed));
			if (rd == 3'd7)
				rd = 3'd0;
			ra = reg_idx_t'($random(seed));
			rb = reg_idx_t'($random(seed));
			imm = imm_t'($random(seed));
			if (op == OP_LDW || op == OP_STW) begin
				ra = 3'd7;
				imm = imm_t'(($random(seed) & 127) << 2);
			end
			put_instr(i, encode(op, rd, ra, rb, imm));
		end
		put_instr(RAND_LEN - 1, encode(OP_HALT, 3'd0, 3'd0, 3'd0, 16'h0000));
	endtask

	// compares one finished APB transfer with the expected streams
	task automatic complete_transfer();
		if (first_xfer) begin
			first_xfer = 1'b0;
			checks++;
			assert (!pwrite && paddr == RESET_PC) else begin
				errors++;
				$display("MISMATCH at %0t: first transfer pwrite=%b at %h, expected read at %h",
					$time, pwrite, paddr, RESET_PC);
			end
		end
		if (pwrite) begin
			mem[paddr[9:2]] = pwdata;
			if (exp_st_addr.size() == 0) begin
				errors++;
				$display("unexpected store to %h at time %0t", paddr, $time);
			end else begin
				checks++;
				assert (paddr == exp_st_addr[0] && pwdata == exp_st_data[0]) else begin
					errors++;
					$display("MISMATCH at %0t: store [%h] = %h, expected [%h] = %h",
						$time, paddr, pwdata, exp_st_addr[0], exp_st_data[0]);
				end
				void'(exp_st_addr.pop_front());
				void'(exp_st_data.pop_front());
			end
		end else if (paddr < DATA_BASE) begin
			if (exp_fetch.size() == 0) begin
				errors++;
				$display("unexpected fetch from %h at time %0t", paddr, $time);
			end else begin
				checks++;
				assert (paddr == exp_fetch[0]) else begin
					errors++;
					$display("MISMATCH at %0t: fetch from %h, expected %h",
						$time, paddr, exp_fetch[0]);
				end
				void'(exp_fetch.pop_front());
			end
		end else begin
			if (exp_ld_addr.size() == 0) begin
				errors++;
				$display("unexpected load from %h at time %0t", paddr, $time);
			end else begin
				checks++;
				assert (paddr == exp_ld_addr[0]) else begin
					errors++;
					$display("MISMATCH at %0t: load from %h, expected %h",
						$time, paddr, exp_ld_addr[0]);
				end
				void'(exp_ld_addr.pop_front());
			end
		end
	endtask

	// APB memory with 0 to 3 wait states per transfer
	initial begin
		pready = 1'b0;
		prdata = '0;
		wait_left = 0;
		forever begin
			@(posedge clk);
			#1;
			pready = 1'b0;
			if (psel && !penable) begin
				wait_left = $random(seed) & 3;
			end else if (psel && penable) begin
				if (wait_left > 0) begin
					wait_left--;
				end else begin
					pready = 1'b1;
					prdata = mem[paddr[9:2]];
					complete_transfer();
				end
			end
		end
	end

	task automatic wait_halted(output bit hit);
		hit = 1'b0;
		for (int n = 0; n < HALT_TIMEOUT && !hit; n++) begin
			@(posedge clk);
			#1;
			if (halted)
				hit = 1'b1;
		end
	endtask

	task automatic run_program(input string name, output bit ok);
		bit hit;
		ref_mem = mem;
		exp_fetch.delete();
		exp_ld_addr.delete();
		exp_st_addr.delete();
		exp_st_data.delete();
		interpret();
		first_xfer = 1'b1;
		rst_n = 1'b0;
		repeat (2) begin
			@(posedge clk);
			#1;
			checks++;
			assert (!psel && !penable && !halted) else begin
				errors++;
				$display("MISMATCH at %0t: psel=%b penable=%b halted=%b in reset",
					$time, psel, penable, halted);
			end
		end
		rst_n = 1'b1;
		wait_halted(hit);
		ok = hit;
		if (!hit) begin
			errors++;
			$display("timeout: %s program did not halt within %0d cycles",
				name, HALT_TIMEOUT);
		end else begin
			if (exp_fetch.size() != 0 || exp_ld_addr.size() != 0 ||
				exp_st_addr.size() != 0) begin
				errors++;
				$display("%s program halted with %0d fetches, %0d loads, %0d stores missing",
					name, exp_fetch.size(), exp_ld_addr.size(), exp_st_addr.size());
			end
			// bus must stay quiet once halted
			repeat (QUIET_CYCLES) begin
				@(posedge clk);
				#1;
				checks++;
				assert (!psel && halted) else begin
					errors++;
					$display("MISMATCH at %0t: psel=%b halted=%b after HALT",
						$time, psel, halted);
				end
			end
		end
	endtask

	initial begin
		bit ok;
		rst_n = 1'b0;
		build_directed();
		run_program("directed", ok);
		if (ok) begin
			build_random();
			run_program("random", ok);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: compile.f
rtl/cpu_pkg.sv
rtl/mem_port_if.sv
rtl/dec_op_if.sv
rtl/fetch_decode.sv
rtl/execute_unit.sv
rtl/reg_result.sv
rtl/mem_bus_guard.sv
rtl/cpu_top.sv
testbench/tb_clock_gen.sv
testbench/cpu_top_chk.sv
testbench/tb_cpu_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cpu_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_cpu_top \
	-f compile.f --Mdir "$BUILD_DIR" -o sim_tb_cpu_top
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/sim_tb_cpu_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failures found" "$LOG"; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0
